// ==== vlog.f ====
design/gbe_cpu_pkg.sv
design/cpu_mem_if.sv
design/gbe_dp_ram.sv
design/gbe_cpu_attach.sv
design/gbe_cpu_subsys.sv
bench/tb_gbe_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the gbe cpu subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_gbe_cpu -f vlog.f -o sim_tb_gbe_cpu
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb_gbe_cpu
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// ==== bench/tb_gbe_cpu.sv ====
`timescale 1ns/1ps

module tb_gbe_cpu
  import gbe_cpu_pkg::*;
();

  localparam mac_t      T_MAC        = 48'h025e_1020_3040;
  localparam ip_t       T_IP         = 32'hc0a8_0102;
  localparam udp_port_t T_PORT       = 16'd10000;
  localparam gw_t       T_GW         = 8'd1;
  localparam logic      T_EN         = 1'b1;
  localparam logic      T_PROM       = 1'b0;
  localparam wb_data_t  T_PHY        = 32'h0000_1140;
  localparam logic      T_TX_EN      = 1'b1;
  localparam logic      T_RX_EN      = 1'b0;
  localparam wb_data_t  T_PHY_STATUS = 32'h0000_796d;

  logic        cpu_clk = 1'b0;
  logic        cpu_rst;
  logic        wb_stb;
  logic        wb_cyc;
  logic        wb_we;
  wb_addr_t    wb_adr;
  wb_data_t    wb_dat_w;
  logic [3:0]  wb_sel;
  wb_data_t    wb_dat_r;
  logic        wb_ack;
  mac_t        local_mac;
  ip_t         local_ip;
  udp_port_t   local_port;
  gw_t         local_gateway;
  logic        local_enable;
  logic        cpu_promiscuous;
  wb_data_t    phy_control;
  wb_data_t    phy_status;
  buf_size_t   tx_size;
  logic        tx_ready;
  logic        tx_done;
  logic        rx_ready;
  buf_size_t   rx_size;
  logic        rx_ack;
  logic [8:0]  tx_rd_addr;
  wb_data_t    tx_rd_data;
  logic [8:0]  rx_wr_addr;
  wb_data_t    rx_wr_data;
  logic        rx_wr_en;
  gw_t         arp_rd_addr;
  mac_t        arp_rd_data;
  logic [31:0] lfsr;
  string       cur_test;

  always #5 cpu_clk = ~cpu_clk;

  gbe_cpu_subsys #(
    .LOCAL_MAC       (T_MAC),
    .LOCAL_IP        (T_IP),
    .LOCAL_PORT      (T_PORT),
    .LOCAL_GATEWAY   (T_GW),
    .LOCAL_ENABLE    (T_EN),
    .CPU_PROMISCUOUS (T_PROM),
    .PHY_CONFIG      (T_PHY),
    .CPU_TX_ENABLE   (T_TX_EN),
    .CPU_RX_ENABLE   (T_RX_EN),
    .BUF_AW          (9),
    .ARP_AW          (8)
  ) DUT (
    .cpu_clk           (cpu_clk),
    .cpu_rst           (cpu_rst),
    .wb_stb_i          (wb_stb),
    .wb_cyc_i          (wb_cyc),
    .wb_we_i           (wb_we),
    .wb_adr_i          (wb_adr),
    .wb_dat_i          (wb_dat_w),
    .wb_sel_i          (wb_sel),
    .wb_dat_o          (wb_dat_r),
    .wb_ack_o          (wb_ack),
    .local_mac_o       (local_mac),
    .local_ip_o        (local_ip),
    .local_port_o      (local_port),
    .local_gateway_o   (local_gateway),
    .local_enable_o    (local_enable),
    .cpu_promiscuous_o (cpu_promiscuous),
    .phy_control_o     (phy_control),
    .phy_status_i      (phy_status),
    .tx_size_o         (tx_size),
    .tx_ready_o        (tx_ready),
    .tx_done_i         (tx_done),
    .rx_ready_i        (rx_ready),
    .rx_size_i         (rx_size),
    .rx_ack_o          (rx_ack),
    .tx_rd_addr_i      (tx_rd_addr),
    .tx_rd_data_o      (tx_rd_data),
    .rx_wr_addr_i      (rx_wr_addr),
    .rx_wr_data_i      (rx_wr_data),
    .rx_wr_en_i        (rx_wr_en),
    .arp_rd_addr_i     (arp_rd_addr),
    .arp_rd_data_o     (arp_rd_data)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  // byte lanes under sel, limited to the writable bits
  function automatic wb_data_t merge_lanes(input wb_data_t old, input wb_data_t d,
                                           input logic [3:0] sel, input wb_data_t wmask);
    wb_data_t m;
    m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}} & wmask;
    return (old & ~m) | (d & m);
  endfunction

  function automatic wb_addr_t reg_adr(input logic [3:0] idx);
    return WIN_REG + {8'b0, idx, 2'b0};
  endfunction

  function automatic wb_addr_t buf_adr(input wb_addr_t base, input logic [8:0] w);
    return base + {3'b0, w, 2'b0};
  endfunction

  function automatic wb_addr_t arp_adr(input gw_t e, input logic lo);
    return WIN_ARP + {3'b0, e, lo, 2'b0};
  endfunction

  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string what, input wb_data_t exp, input wb_data_t act);
    if (exp !== act) begin
      $display("** Error: %s: %s expected %h actual %h", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  task automatic wb_xfer(input logic we, input wb_addr_t adr, input wb_data_t dat,
                         input logic [3:0] sel, output wb_data_t rd);
    int n;
    @(posedge cpu_clk);
    wb_stb   <= 1'b1;
    wb_cyc   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    wb_sel   <= sel;
    n = 0;
    @(negedge cpu_clk);
    while (!wb_ack && n < 10) begin
      @(negedge cpu_clk);
      n++;
    end
    if (!wb_ack) begin
      $display("%s: the bus gave no ack for address %h", cur_test, adr);
      stop_run();
    end
    rd = wb_dat_r;
    @(posedge cpu_clk);
    wb_stb <= 1'b0;
    wb_cyc <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_word(input wb_addr_t adr, input wb_data_t dat, input logic [3:0] sel);
    wb_data_t unused;
    wb_xfer(1'b1, adr, dat, sel, unused);
  endtask

  task automatic read_word(input wb_addr_t adr, output wb_data_t dat);
    wb_xfer(1'b0, adr, 32'd0, 4'hf, dat);
  endtask

  // registered read ports, data one cycle after the address
  task automatic tx_fabric_read(input logic [8:0] a, output wb_data_t d);
    @(posedge cpu_clk);
    tx_rd_addr <= a;
    @(posedge cpu_clk);
    @(negedge cpu_clk);
    d = tx_rd_data;
  endtask

  task automatic arp_fabric_read(input gw_t a, output mac_t d);
    @(posedge cpu_clk);
    arp_rd_addr <= a;
    @(posedge cpu_clk);
    @(negedge cpu_clk);
    d = arp_rd_data;
  endtask

  task automatic wait_rx_ack();
    int n;
    n = 0;
    @(negedge cpu_clk);
    while (!rx_ack && n < 20) begin
      @(negedge cpu_clk);
      n++;
    end
    if (!rx_ack) begin
      $display("%s: rx_ack_o never rose while rx_ready_i was high", cur_test);
      stop_run();
    end
  endtask

  task automatic registers_rw();
    wb_data_t    model [12];
    wb_data_t    mask [12];
    logic [3:0]  idx [6];
    wb_data_t    r;
    logic [63:0] v;
    cur_test = "registers";
    idx = '{REG_MAC_HI, REG_MAC_LO, REG_GATEWAY, REG_IP, REG_PORT_EN, REG_PHY_CONTROL};
    for (int i = 0; i < 12; i++) begin
      model[i] = '0;
      mask[i]  = '0;
    end
    model[REG_MAC_HI]      = {16'b0, T_MAC[47:32]};
    model[REG_MAC_LO]      = T_MAC[31:0];
    model[REG_GATEWAY]     = {24'b0, T_GW};
    model[REG_IP]          = T_IP;
    model[REG_PORT_EN]     = {7'b0, T_PROM, 7'b0, T_EN, T_PORT};
    model[REG_CAPS]        = {7'b0, T_TX_EN, 7'b0, T_RX_EN, 16'b0};
    model[REG_PHY_STATUS]  = T_PHY_STATUS;
    model[REG_PHY_CONTROL] = T_PHY;
    mask[REG_MAC_HI]       = 32'h0000_ffff;
    mask[REG_MAC_LO]       = 32'hffff_ffff;
    mask[REG_GATEWAY]      = 32'h0000_00ff;
    mask[REG_IP]           = 32'hffff_ffff;
    mask[REG_PORT_EN]      = 32'h0101_ffff;
    mask[REG_PHY_CONTROL]  = 32'hffff_ffff;
    for (int i = 0; i < 12; i++) begin
      read_word(reg_adr(4'(i)), r);
      check($sformatf("reset read of index %0d", i), model[i], r);
    end
    for (int n = 0; n < 3; n++) begin
      for (int j = 0; j < 6; j++) begin
        v = lfsr_bits(36);
        write_word(reg_adr(idx[j]), v[31:0], v[35:32]);
        model[idx[j]] = merge_lanes(model[idx[j]], v[31:0], v[35:32], mask[idx[j]]);
      end
    end
    for (int i = 0; i < 12; i++) begin
      read_word(reg_adr(4'(i)), r);
      check($sformatf("readback of index %0d", i), model[i], r);
    end
    @(negedge cpu_clk);
    check("local_mac_o high", model[REG_MAC_HI], {16'b0, local_mac[47:32]});
    check("local_mac_o low", model[REG_MAC_LO], local_mac[31:0]);
    check("local_gateway_o", model[REG_GATEWAY], {24'b0, local_gateway});
    check("local_ip_o", model[REG_IP], local_ip);
    check("port and enables", model[REG_PORT_EN],
          {7'b0, cpu_promiscuous, 7'b0, local_enable, local_port});
    check("phy_control_o", model[REG_PHY_CONTROL], phy_control);
  endtask

  task automatic tx_buffer_rw();
    wb_data_t    model [6];
    logic [8:0]  wa [6];
    wb_data_t    r;
    logic [63:0] v;
    cur_test = "tx_buffer";
    for (int i = 0; i < 6; i++) begin
      wa[i] = 9'(i * 83 + 7);
      v = lfsr_bits(32);
      model[i] = v[31:0];
      write_word(buf_adr(WIN_TX, wa[i]), model[i], 4'hf);
    end
    // partial writes over the earlier words
    for (int i = 0; i < 6; i++) begin
      v = lfsr_bits(36);
      write_word(buf_adr(WIN_TX, wa[i]), v[31:0], v[35:32]);
      model[i] = merge_lanes(model[i], v[31:0], v[35:32], 32'hffff_ffff);
    end
    for (int i = 0; i < 6; i++) begin
      read_word(buf_adr(WIN_TX, wa[i]), r);
      check($sformatf("bus read of word %0d", wa[i]), model[i], r);
      tx_fabric_read(wa[i], r);
      check($sformatf("fabric read of word %0d", wa[i]), model[i], r);
    end
  endtask

  task automatic tx_handshake();
    buf_size_t   sz;
    wb_data_t    r;
    logic [63:0] v;
    cur_test = "tx_handshake";
    v = lfsr_bits(12);
    sz = v[11:0] | 12'h001;
    write_word(reg_adr(REG_BUF_SIZES), {4'b0, sz, 16'b0}, 4'b1100);
    @(negedge cpu_clk);
    check("tx_ready_o after size write", 32'd1, {31'b0, tx_ready});
    check("tx_size_o after size write", {20'b0, sz}, {20'b0, tx_size});
    read_word(reg_adr(REG_BUF_SIZES), r);
    check("size register with tx size", {4'b0, sz, 16'b0}, r);
    @(posedge cpu_clk);
    tx_done <= 1'b1;
    @(posedge cpu_clk);
    tx_done <= 1'b0;
    @(negedge cpu_clk);
    check("tx_ready_o after done", 32'd0, {31'b0, tx_ready});
    check("tx_size_o after done", 32'd0, {20'b0, tx_size});
    read_word(reg_adr(REG_BUF_SIZES), r);
    check("size register after done", 32'd0, r);
  endtask

  task automatic arp_cache_rw();
    mac_t        model [4];
    gw_t         ent [4];
    wb_data_t    r;
    logic [63:0] v;
    mac_t        f;
    cur_test = "arp_cache";
    for (int i = 0; i < 4; i++) begin
      ent[i] = 8'(i * 61 + 2);
      v = lfsr_bits(48);
      model[i] = v[47:0];
      write_word(arp_adr(ent[i], 1'b0), {16'b0, model[i][47:32]}, 4'hf);
      write_word(arp_adr(ent[i], 1'b1), model[i][31:0], 4'hf);
    end
    for (int i = 0; i < 4; i++) begin
      v = lfsr_bits(36);
      write_word(arp_adr(ent[i], 1'b1), v[31:0], v[35:32]);
      model[i][31:0] = merge_lanes(model[i][31:0], v[31:0], v[35:32], 32'hffff_ffff);
      v = lfsr_bits(36);
      write_word(arp_adr(ent[i], 1'b0), v[31:0], v[35:32]);
      r = merge_lanes({16'b0, model[i][47:32]}, v[31:0], v[35:32], 32'h0000_ffff);
      model[i][47:32] = r[15:0];
    end
    for (int i = 0; i < 4; i++) begin
      read_word(arp_adr(ent[i], 1'b0), r);
      check($sformatf("entry %0d high word", ent[i]), {16'b0, model[i][47:32]}, r);
      read_word(arp_adr(ent[i], 1'b1), r);
      check($sformatf("entry %0d low word", ent[i]), model[i][31:0], r);
      arp_fabric_read(ent[i], f);
      check($sformatf("entry %0d fabric high", ent[i]), {16'b0, model[i][47:32]},
            {16'b0, f[47:32]});
      check($sformatf("entry %0d fabric low", ent[i]), model[i][31:0], f[31:0]);
    end
  endtask

  task automatic rx_path();
    wb_data_t    model [5];
    wb_data_t    r;
    logic [63:0] v;
    cur_test = "rx_path";
    // packet engine side fills the buffer
    for (int i = 0; i < 5; i++) begin
      v = lfsr_bits(32);
      model[i] = v[31:0];
      @(posedge cpu_clk);
      rx_wr_addr <= 9'(i);
      rx_wr_data <= model[i];
      rx_wr_en   <= 1'b1;
    end
    @(posedge cpu_clk);
    rx_wr_en <= 1'b0;
    rx_ready <= 1'b1;
    rx_size  <= 12'd20;
    wait_rx_ack();
    @(posedge cpu_clk);
    rx_ready <= 1'b0;
    @(negedge cpu_clk);
    check("rx_ack_o after size taken", 32'd0, {31'b0, rx_ack});
    read_word(reg_adr(REG_BUF_SIZES), r);
    check("rx size", 32'd20, r);
    for (int i = 0; i < 5; i++) begin
      read_word(buf_adr(WIN_RX, 9'(i)), r);
      check($sformatf("rx word %0d", i), model[i], r);
    end
    write_word(buf_adr(WIN_RX, 9'd2), ~model[2], 4'hf);
    read_word(buf_adr(WIN_RX, 9'd2), r);
    check("rx word after bus write", model[2], r);
    // zero size hands the buffer back
    write_word(reg_adr(REG_BUF_SIZES), 32'd0, 4'b0001);
    read_word(reg_adr(REG_BUF_SIZES), r);
    check("rx size after release", 32'd0, r);
    @(posedge cpu_clk);
    rx_ready <= 1'b1;
    rx_size  <= 12'd8;
    wait_rx_ack();
    @(posedge cpu_clk);
    rx_ready <= 1'b0;
    read_word(reg_adr(REG_BUF_SIZES), r);
    check("rx size of second buffer", 32'd8, r);
  endtask

  task automatic unmapped_reads();
    wb_addr_t adr [5];
    wb_data_t r;
    cur_test = "unmapped";
    adr = '{14'h0800, 14'h1800, 14'h2c00, 14'h3ffc, 14'h0008};
    for (int i = 0; i < 5; i++) begin
      write_word(adr[i], 32'hdead_beef, 4'hf);
      read_word(adr[i], r);
      check($sformatf("read of %h", adr[i]), 32'd0, r);
    end
  endtask

  initial begin
    lfsr        = 32'h4554;
    cur_test    = "reset";
    cpu_rst     <= 1'b1;
    wb_stb      <= 1'b0;
    wb_cyc      <= 1'b0;
    wb_we       <= 1'b0;
    wb_adr      <= '0;
    wb_dat_w    <= '0;
    wb_sel      <= 4'h0;
    phy_status  <= T_PHY_STATUS;
    tx_done     <= 1'b0;
    rx_ready    <= 1'b0;
    rx_size     <= '0;
    tx_rd_addr  <= '0;
    rx_wr_addr  <= '0;
    rx_wr_data  <= '0;
    rx_wr_en    <= 1'b0;
    arp_rd_addr <= '0;
    repeat (16) @(posedge cpu_clk);
    cpu_rst <= 1'b0;
    registers_rw();
    tx_buffer_rw();
    tx_handshake();
    arp_cache_rw();
    rx_path();
    unmapped_reads();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== design/gbe_cpu_subsys.sv ====
`timescale 1ns/1ps

module gbe_cpu_subsys
  import gbe_cpu_pkg::*;
#(
  parameter mac_t      LOCAL_MAC       = 48'h0200_0a00_0001,
  parameter ip_t       LOCAL_IP        = 32'hc0a8_0102,
  parameter udp_port_t LOCAL_PORT      = 16'd10000,
  parameter gw_t       LOCAL_GATEWAY   = 8'd1,
  parameter logic      LOCAL_ENABLE    = 1'b0,
  parameter logic      CPU_PROMISCUOUS = 1'b0,
  parameter wb_data_t  PHY_CONFIG      = 32'h0000_0000,
  parameter logic      CPU_TX_ENABLE   = 1'b1,
  parameter logic      CPU_RX_ENABLE   = 1'b1,
  parameter int        BUF_AW          = 9,
  parameter int        ARP_AW          = 8
) (
  input  logic              cpu_clk,
  input  logic              cpu_rst,
  input  logic              wb_stb_i,
  input  logic              wb_cyc_i,
  input  logic              wb_we_i,
  input  wb_addr_t          wb_adr_i,
  input  wb_data_t          wb_dat_i,
  input  logic [3:0]        wb_sel_i,
  output wb_data_t          wb_dat_o,
  output logic              wb_ack_o,
  output mac_t              local_mac_o,
  output ip_t               local_ip_o,
  output udp_port_t         local_port_o,
  output gw_t               local_gateway_o,
  output logic              local_enable_o,
  output logic              cpu_promiscuous_o,
  output wb_data_t          phy_control_o,
  input  wb_data_t          phy_status_i,
  output buf_size_t         tx_size_o,
  output logic              tx_ready_o,
  input  logic              tx_done_i,
  input  logic              rx_ready_i,
  input  buf_size_t         rx_size_i,
  output logic              rx_ack_o,
  input  logic [BUF_AW-1:0] tx_rd_addr_i,
  output wb_data_t          tx_rd_data_o,
  input  logic [BUF_AW-1:0] rx_wr_addr_i,
  input  wb_data_t          rx_wr_data_i,
  input  logic              rx_wr_en_i,
  input  gw_t               arp_rd_addr_i,
  output mac_t              arp_rd_data_o
);

  cpu_mem_if #(.AW(BUF_AW), .DW($bits(wb_data_t))) tx_if ();
  cpu_mem_if #(.AW(BUF_AW), .DW($bits(wb_data_t))) rx_if ();
  cpu_mem_if #(.AW(ARP_AW), .DW($bits(mac_t)))     arp_if ();

  gbe_cpu_attach #(
    .LOCAL_MAC       (LOCAL_MAC),
    .LOCAL_IP        (LOCAL_IP),
    .LOCAL_PORT      (LOCAL_PORT),
    .LOCAL_GATEWAY   (LOCAL_GATEWAY),
    .LOCAL_ENABLE    (LOCAL_ENABLE),
    .CPU_PROMISCUOUS (CPU_PROMISCUOUS),
    .PHY_CONFIG      (PHY_CONFIG),
    .CPU_TX_ENABLE   (CPU_TX_ENABLE),
    .CPU_RX_ENABLE   (CPU_RX_ENABLE),
    .BUF_AW          (BUF_AW),
    .ARP_AW          (ARP_AW)
  ) attach (
    .cpu_clk           (cpu_clk),
    .cpu_rst           (cpu_rst),
    .wb_stb_i          (wb_stb_i),
    .wb_cyc_i          (wb_cyc_i),
    .wb_we_i           (wb_we_i),
    .wb_adr_i          (wb_adr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_sel_i          (wb_sel_i),
    .wb_dat_o          (wb_dat_o),
    .wb_ack_o          (wb_ack_o),
    .local_mac_o       (local_mac_o),
    .local_ip_o        (local_ip_o),
    .local_port_o      (local_port_o),
    .local_gateway_o   (local_gateway_o),
    .local_enable_o    (local_enable_o),
    .cpu_promiscuous_o (cpu_promiscuous_o),
    .phy_control_o     (phy_control_o),
    .phy_status_i      (phy_status_i),
    .tx_size_o         (tx_size_o),
    .tx_ready_o        (tx_ready_o),
    .tx_done_i         (tx_done_i),
    .rx_ready_i        (rx_ready_i),
    .rx_size_i         (rx_size_i),
    .rx_ack_o          (rx_ack_o),
    .tx_mem            (tx_if),
    .rx_mem            (rx_if),
    .arp_mem           (arp_if)
  );

  // packet engine only reads tx and arp, only writes rx
  gbe_dp_ram #(.AW(BUF_AW), .DW($bits(wb_data_t))) tx_ram (
    .cpu_clk       (cpu_clk),
    .cpu           (tx_if),
    .fab_addr_i    (tx_rd_addr_i),
    .fab_wr_data_i ('0),
    .fab_wr_en_i   (1'b0),
    .fab_rd_data_o (tx_rd_data_o)
  );

  gbe_dp_ram #(.AW(BUF_AW), .DW($bits(wb_data_t))) rx_ram (
    .cpu_clk       (cpu_clk),
    .cpu           (rx_if),
    .fab_addr_i    (rx_wr_addr_i),
    .fab_wr_data_i (rx_wr_data_i),
    .fab_wr_en_i   (rx_wr_en_i),
    .fab_rd_data_o ()
  );

  gbe_dp_ram #(.AW(ARP_AW), .DW($bits(mac_t))) arp_ram (
    .cpu_clk       (cpu_clk),
    .cpu           (arp_if),
    .fab_addr_i    (arp_rd_addr_i),
    .fab_wr_data_i ('0),
    .fab_wr_en_i   (1'b0),
    .fab_rd_data_o (arp_rd_data_o)
  );

endmodule

// ==== design/gbe_cpu_attach.sv ====
`timescale 1ns/1ps

module gbe_cpu_attach
  import gbe_cpu_pkg::*;
#(
  parameter mac_t      LOCAL_MAC       = 48'hffff_ffff_ffff,
  parameter ip_t       LOCAL_IP        = 32'hffff_ffff,
  parameter udp_port_t LOCAL_PORT      = 16'hffff,
  parameter gw_t       LOCAL_GATEWAY   = 8'd0,
  parameter logic      LOCAL_ENABLE    = 1'b0,
  parameter logic      CPU_PROMISCUOUS = 1'b0,
  parameter wb_data_t  PHY_CONFIG      = 32'd0,
  parameter logic      CPU_TX_ENABLE   = 1'b0,
  parameter logic      CPU_RX_ENABLE   = 1'b0,
  parameter int        BUF_AW          = 9,
  parameter int        ARP_AW          = 8
) (
  input  logic       cpu_clk,
  input  logic       cpu_rst,
  input  logic       wb_stb_i,
  input  logic       wb_cyc_i,
  input  logic       wb_we_i,
  input  wb_addr_t   wb_adr_i,
  input  wb_data_t   wb_dat_i,
  input  logic [3:0] wb_sel_i,
  output wb_data_t   wb_dat_o,
  output logic       wb_ack_o,
  output mac_t       local_mac_o,
  output ip_t        local_ip_o,
  output udp_port_t  local_port_o,
  output gw_t        local_gateway_o,
  output logic       local_enable_o,
  output logic       cpu_promiscuous_o,
  output wb_data_t   phy_control_o,
  input  wb_data_t   phy_status_i,
  output buf_size_t  tx_size_o,
  output logic       tx_ready_o,
  input  logic       tx_done_i,
  input  logic       rx_ready_i,
  input  buf_size_t  rx_size_i,
  output logic       rx_ack_o,
  cpu_mem_if.master  tx_mem,
  cpu_mem_if.master  rx_mem,
  cpu_mem_if.master  arp_mem
);

  localparam logic [2:0] SRC_NONE = 3'd0;
  localparam logic [2:0] SRC_REG  = 3'd1;
  localparam logic [2:0] SRC_TX   = 3'd2;
  localparam logic [2:0] SRC_RX   = 3'd3;
  localparam logic [2:0] SRC_ARP  = 3'd4;

  bus_state_t  state_q;
  logic        ack_q;
  logic        start;
  logic        reg_win;
  logic        tx_win;
  logic        rx_win;
  logic        arp_win;
  logic [3:0]  reg_idx;
  logic [2:0]  src_q;
  logic [3:0]  src_idx_q;
  logic        arp_lo_q;
  mac_t        local_mac_q;
  ip_t         local_ip_q;
  udp_port_t   local_port_q;
  gw_t         local_gateway_q;
  logic        local_enable_q;
  logic        cpu_promiscuous_q;
  wb_data_t    phy_control_q;
  buf_size_t   tx_size_q;
  logic        tx_ready_q;
  logic [12:0] rx_size_q;
  logic        rx_ack_q;
  wb_data_t    tx_merge;
  mac_t        arp_merge;
  wb_data_t    reg_rd_data;

  function automatic logic in_win(wb_addr_t adr, wb_addr_t base);
    return (adr & ~(WIN_SPAN - 14'd1)) == base;
  endfunction

  assign reg_win = in_win(wb_adr_i, WIN_REG);
  assign tx_win  = in_win(wb_adr_i, WIN_TX);
  assign rx_win  = in_win(wb_adr_i, WIN_RX);
  assign arp_win = in_win(wb_adr_i, WIN_ARP);
  assign reg_idx = wb_adr_i[5:2];

  // new transaction only from idle, ack low
  assign start = wb_stb_i && wb_cyc_i && !ack_q && (state_q == BUS_IDLE);

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      state_q <= BUS_IDLE;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      case (state_q)
        BUS_IDLE: begin
          if (start && wb_we_i && (tx_win || arp_win)) begin
            state_q <= BUS_RMW;
          end else if (start) begin
            ack_q <= 1'b1;
          end
        end
        BUS_RMW: begin
          state_q <= BUS_ACK;
          ack_q   <= 1'b1;
        end
        default: state_q <= BUS_IDLE;
      endcase
    end
  end

  // read source, latched at the start cycle
  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      src_q     <= SRC_NONE;
      src_idx_q <= 4'd0;
      arp_lo_q  <= 1'b0;
    end else if (start) begin
      src_idx_q <= reg_idx;
      arp_lo_q  <= wb_adr_i[2];
      if (reg_win) begin
        src_q <= SRC_REG;
      end else if (tx_win) begin
        src_q <= SRC_TX;
      end else if (rx_win) begin
        src_q <= SRC_RX;
      end else if (arp_win) begin
        src_q <= SRC_ARP;
      end else begin
        src_q <= SRC_NONE;
      end
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      local_mac_q       <= LOCAL_MAC;
      local_ip_q        <= LOCAL_IP;
      local_port_q      <= LOCAL_PORT;
      local_gateway_q   <= LOCAL_GATEWAY;
      local_enable_q    <= LOCAL_ENABLE;
      cpu_promiscuous_q <= CPU_PROMISCUOUS;
      phy_control_q     <= PHY_CONFIG;
      tx_size_q         <= '0;
      tx_ready_q        <= 1'b0;
      rx_size_q         <= '0;
      rx_ack_q          <= 1'b0;
    end else begin
      // packet engine handshakes, bus writes below take priority
      if (tx_done_i) begin
        tx_size_q  <= '0;
        tx_ready_q <= 1'b0;
      end
      if (rx_size_q == 13'd0 && rx_ready_i) begin
        rx_ack_q <= 1'b1;
      end
      if (rx_ready_i && rx_ack_q) begin
        rx_size_q <= {1'b0, rx_size_i};
        rx_ack_q  <= 1'b0;
      end

      if (start && wb_we_i && reg_win) begin
        case (reg_idx)
          REG_MAC_HI: begin
            for (int i = 0; i < 2; i++) begin
              if (wb_sel_i[i]) local_mac_q[32+8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
          end
          REG_MAC_LO: begin
            for (int i = 0; i < 4; i++) begin
              if (wb_sel_i[i]) local_mac_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
          end
          REG_GATEWAY: begin
            if (wb_sel_i[0]) local_gateway_q <= wb_dat_i[7:0];
          end
          REG_IP: begin
            for (int i = 0; i < 4; i++) begin
              if (wb_sel_i[i]) local_ip_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
          end
          REG_BUF_SIZES: begin
            // zero rx size hands the buffer back
            if (wb_sel_i[0] && wb_dat_i[12:0] == 13'd0) rx_size_q <= '0;
            if (wb_sel_i[2]) begin
              tx_size_q[7:0] <= wb_dat_i[23:16];
              tx_ready_q     <= 1'b1;
            end
            if (wb_sel_i[3]) tx_size_q[11:8] <= wb_dat_i[27:24];
          end
          REG_PORT_EN: begin
            if (wb_sel_i[0]) local_port_q[7:0]  <= wb_dat_i[7:0];
            if (wb_sel_i[1]) local_port_q[15:8] <= wb_dat_i[15:8];
            if (wb_sel_i[2]) local_enable_q     <= wb_dat_i[16];
            if (wb_sel_i[3]) cpu_promiscuous_q  <= wb_dat_i[24];
          end
          REG_PHY_CONTROL: begin
            for (int i = 0; i < 4; i++) begin
              if (wb_sel_i[i]) phy_control_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // byte merge against the old word read in the start cycle
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      tx_merge[8*i +: 8] = wb_sel_i[i] ? wb_dat_i[8*i +: 8] : tx_mem.rd_data[8*i +: 8];
    end
    arp_merge = arp_mem.rd_data;
    if (wb_adr_i[2]) begin
      for (int i = 0; i < 4; i++) begin
        if (wb_sel_i[i]) arp_merge[8*i +: 8] = wb_dat_i[8*i +: 8];
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (wb_sel_i[i]) arp_merge[32+8*i +: 8] = wb_dat_i[8*i +: 8];
      end
    end
  end

  assign tx_mem.addr     = wb_adr_i[BUF_AW+1:2];
  assign tx_mem.wr_data  = tx_merge;
  assign tx_mem.wr_en    = (state_q == BUS_RMW) && tx_win;
  assign rx_mem.addr     = wb_adr_i[BUF_AW+1:2];
  assign rx_mem.wr_data  = '0;
  assign rx_mem.wr_en    = 1'b0;
  assign arp_mem.addr    = wb_adr_i[ARP_AW+2:3];
  assign arp_mem.wr_data = arp_merge;
  assign arp_mem.wr_en   = (state_q == BUS_RMW) && arp_win;

  always_comb begin
    case (src_idx_q)
      REG_MAC_HI:      reg_rd_data = {16'b0, local_mac_q[47:32]};
      REG_MAC_LO:      reg_rd_data = local_mac_q[31:0];
      REG_GATEWAY:     reg_rd_data = {24'b0, local_gateway_q};
      REG_IP:          reg_rd_data = local_ip_q;
      REG_BUF_SIZES:   reg_rd_data = {4'b0, tx_size_q, 3'b0, rx_ack_q ? 13'b0 : rx_size_q};
      REG_PORT_EN:     reg_rd_data = {7'b0, cpu_promiscuous_q, 7'b0, local_enable_q,
                                      local_port_q};
      REG_CAPS:        reg_rd_data = {7'b0, CPU_TX_ENABLE, 7'b0, CPU_RX_ENABLE, 16'b0};
      REG_PHY_STATUS:  reg_rd_data = phy_status_i;
      REG_PHY_CONTROL: reg_rd_data = phy_control_q;
      default:         reg_rd_data = '0;
    endcase
  end

  always_comb begin
    case (src_q)
      SRC_REG: wb_dat_o = reg_rd_data;
      SRC_TX:  wb_dat_o = tx_mem.rd_data;
      SRC_RX:  wb_dat_o = rx_mem.rd_data;
      // arp entry split over two words
      SRC_ARP: wb_dat_o = arp_lo_q ? arp_mem.rd_data[31:0] : {16'b0, arp_mem.rd_data[47:32]};
      default: wb_dat_o = '0;
    endcase
  end

  assign wb_ack_o          = ack_q;
  assign local_mac_o       = local_mac_q;
  assign local_ip_o        = local_ip_q;
  assign local_port_o      = local_port_q;
  assign local_gateway_o   = local_gateway_q;
  assign local_enable_o    = local_enable_q;
  assign cpu_promiscuous_o = cpu_promiscuous_q;
  assign phy_control_o     = phy_control_q;
  assign tx_size_o         = tx_size_q;
  assign tx_ready_o        = tx_ready_q;
  assign rx_ack_o          = rx_ack_q;

  a_ack_single: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    wb_ack_o |=> !wb_ack_o);

  // memory writes only in the rmw cycle
  a_wr_in_rmw: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    (tx_mem.wr_en || arp_mem.wr_en || rx_mem.wr_en) |-> (state_q == BUS_RMW));

endmodule

// ==== design/gbe_dp_ram.sv ====
`timescale 1ns/1ps

module gbe_dp_ram #(
  parameter int AW = 9,
  parameter int DW = 32
) (
  input  logic          cpu_clk,
  cpu_mem_if.ram        cpu,
  input  logic [AW-1:0] fab_addr_i,
  input  logic [DW-1:0] fab_wr_data_i,
  input  logic          fab_wr_en_i,
  output logic [DW-1:0] fab_rd_data_o
);

  logic [DW-1:0] mem [2**AW];

  // both ports read the old word on a write
  always_ff @(posedge cpu_clk) begin
    if (cpu.wr_en) begin
      mem[cpu.addr] <= cpu.wr_data;
    end
    if (fab_wr_en_i) begin
      mem[fab_addr_i] <= fab_wr_data_i;
    end
    cpu.rd_data   <= mem[cpu.addr];
    fab_rd_data_o <= mem[fab_addr_i];
  end

  a_no_write_clash: assert property (@(posedge cpu_clk)
    (cpu.wr_en && fab_wr_en_i) |-> (cpu.addr != fab_addr_i));

endmodule

// ==== design/cpu_mem_if.sv ====
`timescale 1ns/1ps

interface cpu_mem_if #(
  parameter int AW = 9,
  parameter int DW = 32
);

  logic [AW-1:0] addr;
  logic [DW-1:0] rd_data;
  logic [DW-1:0] wr_data;
  logic          wr_en;

  modport master (
    output addr,
    output wr_data,
    output wr_en,
    input  rd_data
  );

  modport ram (
    input  addr,
    input  wr_data,
    input  wr_en,
    output rd_data
  );

endinterface

// ==== design/gbe_cpu_pkg.sv ====
package gbe_cpu_pkg;

  typedef logic [47:0] mac_t;
  typedef logic [31:0] ip_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [7:0]  gw_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [13:0] wb_addr_t;
  typedef logic [11:0] buf_size_t;

  // window bases, each window is WIN_SPAN bytes wide
  localparam wb_addr_t WIN_REG  = 14'h0000;
  localparam wb_addr_t WIN_TX   = 14'h1000;
  localparam wb_addr_t WIN_RX   = 14'h2000;
  localparam wb_addr_t WIN_ARP  = 14'h3000;
  localparam wb_addr_t WIN_SPAN = 14'h0800;

  // register index from address bits 5:2
  localparam logic [3:0] REG_MAC_HI      = 4'd0;
  localparam logic [3:0] REG_MAC_LO      = 4'd1;
  localparam logic [3:0] REG_GATEWAY     = 4'd3;
  localparam logic [3:0] REG_IP          = 4'd4;
  localparam logic [3:0] REG_BUF_SIZES   = 4'd6;
  localparam logic [3:0] REG_PORT_EN     = 4'd8;
  localparam logic [3:0] REG_CAPS        = 4'd9;
  localparam logic [3:0] REG_PHY_STATUS  = 4'd10;
  localparam logic [3:0] REG_PHY_CONTROL = 4'd11;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_RMW,
    BUS_ACK
  } bus_state_t;

endpackage
